/* approx_div_top.sv */
`timescale 1ns/1ns
`default_nettype none

module approx_div_top #(
  parameter int APPROX_DEPTH = 4
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  input  logic [div_pkg::N_W-1:0]   n,
  input  logic [div_pkg::D_W-1:0]   d,
  input  div_pkg::div_mode_e        mode,
  input  logic                      clear_stats,
  output logic                      out_valid,
  output logic [div_pkg::D_W-1:0]   q,
  output logic [div_pkg::D_W-1:0]   r,
  output logic                      ovf,
  output logic [div_pkg::CNT_W-1:0] sample_count,
  output logic [div_pkg::CNT_W-1:0] err_count,
  output logic [div_pkg::SUM_W-1:0] err_sum,
  output logic [div_pkg::D_W-1:0]   max_err
);

  div_result_if res_if ();  // Both quotients toward the statistics

  div_unit #(
    .APPROX_DEPTH (APPROX_DEPTH)
  ) unit0 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .n         (n),
    .d         (d),
    .mode      (mode),
    .q         (q),
    .r         (r),
    .ovf       (ovf),
    .out_valid (out_valid),
    .res       (res_if.src)
  );

  err_accum stats0 (
    .clk          (clk),
    .rst          (rst),
    .clear_stats  (clear_stats),
    .res          (res_if.dst),
    .sample_count (sample_count),
    .err_count    (err_count),
    .err_sum      (err_sum),
    .max_err      (max_err)
  );

endmodule

`default_nettype wire

/* div_array.sv */
`timescale 1ns/1ns
`default_nettype none

module div_array #(
  parameter int APPROX_DEPTH = 4
) (
  input  logic [div_pkg::N_W-1:0] n,
  input  logic [div_pkg::D_W-1:0] d,
  output logic [div_pkg::D_W-1:0] q,
  output logic [div_pkg::D_W-1:0] r
);

  localparam int W = div_pkg::D_W;

  logic [W-1:0] win   [W];    // Row window before the subtraction
  logic [W:0]   bw    [W];    // Borrow chain, bit W is the row borrow out
  logic [W-1:0] dif   [W];
  logic [W-1:0] prem  [W+1];  // Partial remainder leaving each row
  logic [W-1:0] above;        // Bit just above each row window

  // Full subtractor, returns {borrow, difference}
  function automatic logic [1:0] exact_cell(
    input logic x,
    input logic y,
    input logic bin
  );
    logic bout;
    logic df;
    bout = (~x & y) | (~(x ^ y) & bin);
    df   = x ^ y ^ bin;
    return {bout, df};
  endfunction

  // Reduced cell for the low corner of the triangle
  function automatic logic [1:0] approx_cell(
    input logic x,
    input logic y,
    input logic bin
  );
    logic bout;
    logic df;
    bout = (~x & y) | (x & y & bin);
    df   = x & ~y;  // Borrow in ignored
    return {bout, df};
  endfunction

  always_comb begin
    prem[W] = n[div_pkg::N_W-1 -: W];  // Upper byte seeds the top row
    for (int k = W - 1; k >= 0; k--) begin
      win[k]   = {prem[k+1][W-2:0], n[k]};
      above[k] = prem[k+1][W-1];
      bw[k][0] = 1'b0;
      for (int j = 0; j < W; j++) begin
        if (j + k < APPROX_DEPTH) begin
          {bw[k][j+1], dif[k][j]} = approx_cell(win[k][j], d[j], bw[k][j]);
        end else begin
          {bw[k][j+1], dif[k][j]} = exact_cell(win[k][j], d[j], bw[k][j]);
        end
      end
      q[k]    = above[k] | ~bw[k][W];       // Divisor fits in the window
      prem[k] = q[k] ? dif[k] : win[k];     // Restore on a failed subtract
    end
    r = prem[0];
  end

endmodule

`default_nettype wire

/* div_pkg.sv */
`default_nettype none

package div_pkg;

  localparam int N_W = 16;    // Dividend
  localparam int D_W = 8;     // Divisor, quotient and remainder

  localparam int CNT_W = 16;  // Sample and error counters
  localparam int SUM_W = 24;  // Sum of absolute quotient errors

  // Result returned on q and r
  typedef enum logic {
    MODE_EXACT  = 1'b0,
    MODE_APPROX = 1'b1
  } div_mode_e;

endpackage

`default_nettype wire

/* div_result_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface div_result_if;

  logic                    valid;     // One-cycle strobe, no handshake
  logic [div_pkg::D_W-1:0] q_exact;
  logic [div_pkg::D_W-1:0] q_approx;
  logic                    ovf;       // Quotient does not fit or d is zero

  modport src (
    output valid,
    output q_exact,
    output q_approx,
    output ovf
  );

  modport dst (
    input valid,
    input q_exact,
    input q_approx,
    input ovf
  );

endinterface

`default_nettype wire

/* div_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module div_unit #(
  parameter int APPROX_DEPTH = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  logic [div_pkg::N_W-1:0] n,
  input  logic [div_pkg::D_W-1:0] d,
  input  div_pkg::div_mode_e      mode,
  output logic [div_pkg::D_W-1:0] q,
  output logic [div_pkg::D_W-1:0] r,
  output logic                    ovf,
  output logic                    out_valid,
  div_result_if.src               res
);

  localparam int EXT_W = div_pkg::N_W - div_pkg::D_W;

  logic                    valid_s1;
  logic [div_pkg::N_W-1:0] n_s1;
  logic [div_pkg::D_W-1:0] d_s1;
  div_pkg::div_mode_e      mode_s1;
  logic                    ovf_s1;

  logic [div_pkg::D_W-1:0] q_ex;
  logic [div_pkg::D_W-1:0] r_ex;
  logic [div_pkg::D_W-1:0] q_ap;
  logic [div_pkg::D_W-1:0] r_ap;

  logic                    valid_s2;
  logic [div_pkg::D_W-1:0] q_ex_s2;
  logic [div_pkg::D_W-1:0] q_ap_s2;
  logic [div_pkg::D_W-1:0] r_s2;
  logic                    ovf_s2;
  div_pkg::div_mode_e      mode_s2;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_s1 <= 1'b0;
      valid_s2 <= 1'b0;
    end else begin
      valid_s1 <= in_valid;
      valid_s2 <= valid_s1;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      n_s1    <= n;
      d_s1    <= d;
      mode_s1 <= mode;
    end
  end

  div_array #(.APPROX_DEPTH(0)) exact_arr (
    .n (n_s1),
    .d (d_s1),
    .q (q_ex),
    .r (r_ex)
  );

  div_array #(.APPROX_DEPTH(APPROX_DEPTH)) approx_arr (
    .n (n_s1),
    .d (d_s1),
    .q (q_ap),
    .r (r_ap)
  );

  // Quotient needs more than D_W bits
  assign ovf_s1 = (d_s1 == '0) || (n_s1[div_pkg::N_W-1 -: div_pkg::D_W] >= d_s1);

  always_ff @(posedge clk) begin
    if (valid_s1) begin
      q_ex_s2 <= q_ex;
      q_ap_s2 <= q_ap;
      r_s2    <= (mode_s1 == div_pkg::MODE_APPROX) ? r_ap : r_ex;
      ovf_s2  <= ovf_s1;
      mode_s2 <= mode_s1;
    end
  end

  assign q         = (mode_s2 == div_pkg::MODE_APPROX) ? q_ap_s2 : q_ex_s2;
  assign r         = r_s2;
  assign ovf       = ovf_s2;
  assign out_valid = valid_s2;

  assign res.valid    = valid_s2;
  assign res.q_exact  = q_ex_s2;
  assign res.q_approx = q_ap_s2;
  assign res.ovf      = ovf_s2;

  a_valid_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(out_valid));

  // Operands were in stage one on the edge before the strobe
  a_exact_identity: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !ovf && mode_s2 == div_pkg::MODE_EXACT) |->
      (({{EXT_W{1'b0}}, q} * {{EXT_W{1'b0}}, $past(d_s1)} + {{EXT_W{1'b0}}, r})
        == $past(n_s1)) && (r < $past(d_s1)));

endmodule

`default_nettype wire

/* err_accum.sv */
`timescale 1ns/1ns
`default_nettype none

module err_accum (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      clear_stats,
  div_result_if.dst                 res,
  output logic [div_pkg::CNT_W-1:0] sample_count,
  output logic [div_pkg::CNT_W-1:0] err_count,
  output logic [div_pkg::SUM_W-1:0] err_sum,
  output logic [div_pkg::D_W-1:0]   max_err
);

  localparam int PAD_W = div_pkg::SUM_W - div_pkg::D_W + 1;

  logic                      take;
  logic [div_pkg::D_W-1:0]   abs_err;
  logic [div_pkg::SUM_W:0]   sum_ext;  // Extra bit catches the carry

  assign take = res.valid && !res.ovf;  // Overflow samples are skipped

  assign abs_err = (res.q_approx >= res.q_exact) ? res.q_approx - res.q_exact
                                                 : res.q_exact - res.q_approx;

  assign sum_ext = {1'b0, err_sum} + {{PAD_W{1'b0}}, abs_err};

  always_ff @(posedge clk) begin
    if (rst || clear_stats) begin
      sample_count <= '0;
      err_count    <= '0;
      err_sum      <= '0;
      max_err      <= '0;
    end else if (take) begin
      if (sample_count != '1) begin
        sample_count <= sample_count + 1'b1;
      end
      if (abs_err != '0 && err_count != '1) begin
        err_count <= err_count + 1'b1;
      end
      err_sum <= sum_ext[div_pkg::SUM_W] ? '1 : sum_ext[div_pkg::SUM_W-1:0];
      if (abs_err > max_err) begin
        max_err <= abs_err;
      end
    end
  end

  // A nonzero peak needs at least one counted error
  a_max_needs_err: assert property (@(posedge clk) disable iff (rst)
    (err_count == '0) |-> (max_err == '0));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_top -o tb_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_sim > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi

cat sim.log

if grep -q "Some tests failed" sim.log; then
  echo "FAIL"
  exit 1
fi

echo "PASS"
exit 0

/* src.f */
div_pkg.sv
div_result_if.sv
div_array.sv
div_unit.sv
err_accum.sv
approx_div_top.sv
tb_checker.sv
tb_top.sv

/* tb_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_checker #(
  parameter int APPROX_DEPTH = 4
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  input  logic [div_pkg::N_W-1:0]   n,
  input  logic [div_pkg::D_W-1:0]   d,
  input  div_pkg::div_mode_e        mode,
  input  logic                      clear_stats,
  input  logic                      out_valid,
  input  logic [div_pkg::D_W-1:0]   q,
  input  logic [div_pkg::D_W-1:0]   r,
  input  logic                      ovf,
  input  logic [div_pkg::CNT_W-1:0] sample_count,
  input  logic [div_pkg::CNT_W-1:0] err_count,
  input  logic [div_pkg::SUM_W-1:0] err_sum,
  input  logic [div_pkg::D_W-1:0]   max_err,
  input  logic                      test_end,
  input  int                        test_id,
  input  logic                      final_report,
  output int                        pending,
  output int                        err_total
);

  typedef struct packed {
    logic [15:0] n;
    logic [7:0]  d;
    logic        approx;
    logic [31:0] due;     // Cycle on which out_valid must show
  } op_t;

  op_t         op_q[$];
  op_t         op;
  op_t         nxt;
  int          cyc;
  int          checks;
  int          test_checks;
  int          test_errs;
  int          tests_done;
  logic [15:0] m_samples;
  logic [15:0] m_errs;
  logic [23:0] m_sum;
  logic [7:0]  m_max;
  logic [15:0] ex_res;
  logic [15:0] ap_res;
  logic [7:0]  exp_q;
  logic [7:0]  exp_r;
  logic        exp_ovf;
  logic [7:0]  diff;
  logic [24:0] sum_ext;

  // Bit-level array model returning {quotient, remainder}
  function automatic logic [15:0] array_model(input logic [15:0] nn, input logic [7:0] dd,
                                              input int depth);
    logic [7:0] rem;
    logic [7:0] qv;
    logic [8:0] win;
    logic [7:0] dv;
    logic       b;
    logic       x;
    logic       y;
    rem = nn[15:8];
    for (int k = 7; k >= 0; k--) begin
      win = {rem, nn[k]};
      b   = 1'b0;
      for (int j = 0; j < 8; j++) begin
        x = win[j];
        y = dd[j];
        if (j + k < depth) begin
          dv[j] = x & ~y;
          b     = (~x & y) | (x & y & b);
        end else begin
          dv[j] = x ^ y ^ b;
          b     = (~x & y) | (~(x ^ y) & b);
        end
      end
      qv[k] = win[8] | ~b;
      rem   = qv[k] ? dv : win[7:0];
    end
    return {qv, rem};
  endfunction

  function automatic string test_label(input int id);
    case (id)
      0:       return "reset";
      1:       return "exact";
      2:       return "approx";
      3:       return "overflow";
      4:       return "stats";
      5:       return "idle";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_val(input string sig, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    test_checks++;
    if (act !== exp) begin
      err_total++;
      test_errs++;
      $display("ERR t=%0t %s expected %0h got %0h", $time, sig, exp, act);
    end
  endtask

  task automatic fail_plain(input string msg);
    err_total++;
    test_errs++;
    $display("Failure at %0t: %s", $time, msg);
  endtask

  always @(posedge clk) begin
    if (rst) begin
      op_q.delete();
      cyc       = 0;
      m_samples = '0;
      m_errs    = '0;
      m_sum     = '0;
      m_max     = '0;
    end else begin
      cyc++;
      check_val("sample_count", 32'(m_samples), 32'(sample_count));
      check_val("err_count", 32'(m_errs), 32'(err_count));
      check_val("err_sum", 32'(m_sum), 32'(err_sum));
      check_val("max_err", 32'(m_max), 32'(max_err));
      if (out_valid) begin
        if (op_q.size() == 0) begin
          fail_plain("out_valid went high with no operand in flight");
        end else begin
          op = op_q.pop_front();
          if (op.due != cyc) begin
            fail_plain("out_valid came earlier than two cycles after in_valid");
          end
          ex_res  = array_model(op.n, op.d, 0);
          ap_res  = array_model(op.n, op.d, APPROX_DEPTH);
          // Quotient would need more than eight bits
          exp_ovf = (op.d == 8'h00) || ((32'(op.n) / 32'(op.d)) > 32'd255);
          {exp_q, exp_r} = op.approx ? ap_res : ex_res;
          check_val("ovf", 32'(exp_ovf), 32'(ovf));
          check_val("q", 32'(exp_q), 32'(q));
          check_val("r", 32'(exp_r), 32'(r));
          if (!exp_ovf && !op.approx) begin
            check_val("q", 32'(op.n) / 32'(op.d), 32'(q));  // Plain integer division
            check_val("r", 32'(op.n) % 32'(op.d), 32'(r));
          end
          if (!exp_ovf && !clear_stats) begin
            diff = (ap_res[15:8] >= ex_res[15:8]) ? ap_res[15:8] - ex_res[15:8]
                                                  : ex_res[15:8] - ap_res[15:8];
            if (m_samples != 16'hffff) m_samples++;
            if (diff != 8'h00 && m_errs != 16'hffff) m_errs++;
            sum_ext = {1'b0, m_sum} + {17'b0, diff};
            m_sum   = sum_ext[24] ? 24'hffffff : sum_ext[23:0];
            if (diff > m_max) m_max = diff;
          end
        end
      end else if (op_q.size() != 0 && op_q[0].due <= cyc) begin
        op = op_q.pop_front();
        fail_plain("out_valid did not arrive two cycles after in_valid");
      end
      if (clear_stats) begin
        m_samples = '0;
        m_errs    = '0;
        m_sum     = '0;
        m_max     = '0;
      end
      if (in_valid) begin
        nxt.n      = n;
        nxt.d      = d;
        nxt.approx = (mode == div_pkg::MODE_APPROX);
        nxt.due    = cyc + 2;
        op_q.push_back(nxt);
      end
    end
    if (test_end) begin
      tests_done++;
      $display("test %0d %s: %0d checks, %0d errors", test_id, test_label(test_id),
               test_checks, test_errs);
      test_checks = 0;
      test_errs   = 0;
    end
    if (final_report) begin
      $display("Summary: %0d tests, %0d checks, %0d errors", tests_done, checks, err_total);
    end
    pending = op_q.size();
  end

endmodule

`default_nettype wire

/* tb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_top;

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 8;
  localparam int N_EXACT    = 200;
  localparam int N_APPROX   = 200;
  localparam int N_OVF      = 120;
  localparam int N_STATS    = 300;
  localparam int N_IDLE     = 100;
  localparam int MAX_GAP    = 3;
  localparam int N_TESTS    = 6;
  // Operands, idle gaps, a drain per test and a fixed margin
  localparam int LIMIT_CYCLES = RST_CYCLES + N_EXACT + N_APPROX + N_OVF + N_STATS
                                + N_IDLE * (MAX_GAP + 1) + N_TESTS * 12 + 200;

  logic                      clk;
  logic                      rst;
  logic                      in_valid;
  logic [div_pkg::N_W-1:0]   n;
  logic [div_pkg::D_W-1:0]   d;
  div_pkg::div_mode_e        mode;
  logic                      clear_stats;
  logic                      out_valid;
  logic [div_pkg::D_W-1:0]   q;
  logic [div_pkg::D_W-1:0]   r;
  logic                      ovf;
  logic [div_pkg::CNT_W-1:0] sample_count;
  logic [div_pkg::CNT_W-1:0] err_count;
  logic [div_pkg::SUM_W-1:0] err_sum;
  logic [div_pkg::D_W-1:0]   max_err;
  logic                      test_end;
  int                        test_id;
  logic                      final_report;
  int                        pending;     // Results still owed by the DUT
  int                        err_total;

  approx_div_top #(.APPROX_DEPTH(4)) dut0 (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .n            (n),
    .d            (d),
    .mode         (mode),
    .clear_stats  (clear_stats),
    .out_valid    (out_valid),
    .q            (q),
    .r            (r),
    .ovf          (ovf),
    .sample_count (sample_count),
    .err_count    (err_count),
    .err_sum      (err_sum),
    .max_err      (max_err)
  );

  tb_checker #(.APPROX_DEPTH(4)) chk0 (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .n            (n),
    .d            (d),
    .mode         (mode),
    .clear_stats  (clear_stats),
    .out_valid    (out_valid),
    .q            (q),
    .r            (r),
    .ovf          (ovf),
    .sample_count (sample_count),
    .err_count    (err_count),
    .err_sum      (err_sum),
    .max_err      (max_err),
    .test_end     (test_end),
    .test_id      (test_id),
    .final_report (final_report),
    .pending      (pending),
    .err_total    (err_total)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Upper byte below a nonzero divisor, so the quotient fits
  function automatic logic [23:0] fit_pair();
    logic [7:0] dv;
    logic [7:0] hi;
    logic [7:0] lo;
    dv = 8'($urandom_range(255, 1));
    hi = 8'($urandom % 32'(dv));
    lo = 8'($urandom);
    return {hi, lo, dv};
  endfunction

  function automatic logic [23:0] mixed_pair();
    logic [7:0] dv;
    int         kind;
    kind = int'($urandom_range(3, 0));
    dv   = 8'($urandom_range(255, 1));
    if (kind == 0) begin
      return {16'($urandom), 8'h00};  // Divide by zero
    end else if (kind == 1) begin
      return {8'($urandom_range(255, 32'(dv))), 8'($urandom), dv};
    end
    return fit_pair();
  endfunction

  function automatic div_pkg::div_mode_e random_mode();
    return div_pkg::div_mode_e'(1'($urandom_range(1, 0)));
  endfunction

  task automatic send_op(input logic [23:0] pair, input div_pkg::div_mode_e m);
    @(negedge clk);
    in_valid = 1'b1;
    n        = pair[23:8];
    d        = pair[7:0];
    mode     = m;
  endtask

  // Operand bus keeps changing while in_valid is low
  task automatic go_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      in_valid = 1'b0;
      n        = 16'($urandom);
      d        = 8'($urandom);
      mode     = random_mode();
    end
  endtask

  task automatic drain();
    @(negedge clk);
    in_valid = 1'b0;
    while (pending != 0) @(negedge clk);
    repeat (3) @(negedge clk);  // Statistics settle one cycle after the strobe
  endtask

  task automatic end_test(input int id);
    drain();
    test_id  = id;
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  initial begin
    void'($urandom(32'hd080));
    rst          = 1'b1;
    in_valid     = 1'b0;
    n            = '0;
    d            = '0;
    mode         = div_pkg::MODE_EXACT;
    clear_stats  = 1'b0;
    test_end     = 1'b0;
    test_id      = 0;
    final_report = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    end_test(0);

    repeat (N_EXACT) send_op(fit_pair(), div_pkg::MODE_EXACT);
    end_test(1);

    repeat (N_APPROX) send_op(fit_pair(), div_pkg::MODE_APPROX);
    end_test(2);

    repeat (N_OVF) send_op(mixed_pair(), random_mode());
    end_test(3);

    repeat (N_STATS) begin
      send_op(($urandom_range(3, 0) == 0) ? mixed_pair() : fit_pair(), random_mode());
    end
    drain();
    clear_stats = 1'b1;
    @(negedge clk);
    clear_stats = 1'b0;
    end_test(4);

    repeat (N_IDLE) begin
      send_op(fit_pair(), random_mode());
      go_idle(int'($urandom_range(MAX_GAP, 0)));
    end
    end_test(5);

    final_report = 1'b1;
    @(negedge clk);
    final_report = 1'b0;
    if (err_total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire
